//--- Bender.yml
package:
  name: mc_cpu

sources:
  - src/mc_pkg.sv
  - src/state_control.sv
  - src/instr_decode.sv
  - src/datapath.sv
  - src/cpu_top.sv
  - target: test
    files:
      - bench/tb_clock.sv
      - bench/cpu_tb.sv

//--- bench/cpu_tb.sv
`timescale 1ns/1ps

module cpu_tb;
    import mc_pkg::*;

    localparam int clk_period   = 100;
    localparam int drive_delay  = 10;
    localparam int reset_cycles = 5;
    localparam int quiet_cycles = 20;
    localparam int stim_depth   = 256;
    localparam int mem_depth    = 1 << addr_w;

    logic              clk;
    logic              reset_n;
    logic [word_w-1:0] mem_rdata;
    logic [addr_w-1:0] mem_addr;
    logic [word_w-1:0] mem_wdata;
    logic              mem_read;
    logic              mem_write;
    logic              halted;

    logic [word_w-1:0] mem [mem_depth];
    logic [word_w-1:0] stim [stim_depth];
    // address and data, two entries per store
    logic [word_w-1:0] store_exp [$];
    logic [addr_w-1:0] fetch_exp [$];

    int                prog_len = 0;
    int                cycle = 0;
    int                value_errors = 0;
    int                other_errors = 0;
    int                fetch_count = 0;
    int                store_count = 0;
    int                last_fetch_cycle = 0;
    int                last_fetch_len = 0;
    int                rd_wait = 0;
    logic [addr_w-1:0] rd_addr;
    logic              wr_pend = 1'b0;
    logic [addr_w-1:0] wr_addr;
    logic [word_w-1:0] wr_data;
    bit                file_ok;

    tb_clock #(.period_ns(clk_period)) u_clock (.clk(clk));

    cpu_top DUT (
        .clk       (clk),
        .reset_n   (reset_n),
        .mem_rdata (mem_rdata),
        .mem_addr  (mem_addr),
        .mem_wdata (mem_wdata),
        .mem_read  (mem_read),
        .mem_write (mem_write),
        .halted    (halted)
    );

    // fetch to fetch distance for each instruction class
    function automatic int instr_cycles(logic [3:0] op);
        case (op)
            op_alu, op_addi: return 8;
            op_lw:           return 12;
            op_sw:           return 11;
            op_beq, op_jal:  return 7;
            default:         return 0;
        endcase
    endfunction

    task automatic load_stimulus();
        int pos;
        int n;
        for (int a = 0; a < mem_depth; a++) begin
            mem[a] = {a[7:0] ^ 8'h3c, a[7:0]};
        end
        $readmemh("bench/stimulus.mem", stim);
        file_ok = !$isunknown(stim[0]);
        if (file_ok) begin
            prog_len = stim[0];
            for (int i = 0; i < prog_len; i++) begin
                mem[i] = stim[1 + i];
            end
            pos = 1 + prog_len;
            n = stim[pos];
            for (int i = 0; i < 2 * n; i++) begin
                store_exp.push_back(stim[pos + 1 + i]);
            end
            pos = pos + 1 + 2 * n;
            n = stim[pos];
            for (int i = 0; i < n; i++) begin
                fetch_exp.push_back(stim[pos + 1 + i][addr_w-1:0]);
            end
        end
    endtask

    task automatic check_fetch();
        int spacing;
        if (fetch_count == 0 && cycle != reset_cycles + 1) begin
            $display("first fetch at cycle %0d, one cycle after reset release expected", cycle);
            other_errors++;
        end
        if (fetch_count > 0 && last_fetch_len != 0) begin
            spacing = cycle - last_fetch_cycle;
            if (spacing != last_fetch_len) begin
                $display("FAILED fetch spacing at %h: expected %h, got %h",
                         mem_addr, last_fetch_len, spacing);
                value_errors++;
            end
        end
        if (fetch_count >= fetch_exp.size()) begin
            $display("unexpected extra fetch from address %h", mem_addr);
            other_errors++;
        end else if (mem_addr !== fetch_exp[fetch_count]) begin
            $display("FAILED mem_addr on fetch %0d: expected %h, got %h",
                     fetch_count, fetch_exp[fetch_count], mem_addr);
            value_errors++;
        end
        last_fetch_cycle = cycle;
        last_fetch_len   = instr_cycles(mem[mem_addr][15:12]);
        fetch_count++;
    endtask

    task automatic check_store();
        logic [word_w-1:0] exp_addr;
        logic [word_w-1:0] exp_data;
        if (store_count >= store_exp.size() / 2) begin
            $display("unexpected extra store to address %h", mem_addr);
            other_errors++;
        end else begin
            exp_addr = store_exp[2 * store_count];
            exp_data = store_exp[2 * store_count + 1];
            if (mem_addr !== exp_addr[addr_w-1:0]) begin
                $display("FAILED mem_addr on store %0d: expected %h, got %h",
                         store_count, exp_addr[addr_w-1:0], mem_addr);
                value_errors++;
            end
            if (mem_wdata !== exp_data) begin
                $display("FAILED mem_wdata on store %0d: expected %h, got %h",
                         store_count, exp_data, mem_wdata);
                value_errors++;
            end
        end
        store_count++;
    endtask

    task automatic report_counts();
        $display("errors: %0d value mismatches, %0d other; %0d fetches, %0d stores seen",
                 value_errors, other_errors, fetch_count, store_count);
    endtask

    // strobes sampled mid-cycle
    always @(negedge clk) begin
        if (cycle > 0 && fetch_count == 0) begin
            if (mem_write !== 1'b0 || halted !== 1'b0 ||
                (mem_read !== 1'b0 && cycle != reset_cycles + 1)) begin
                $display("strobe or halted active in reset or init at cycle %0d", cycle);
                other_errors++;
            end
        end
        if (mem_read === 1'b1 && DUT.i_or_d === 1'b0) begin
            check_fetch();
        end
        if (mem_read === 1'b1) begin
            // one extra step since the count starts before the sampling edge
            rd_wait = mem_latency + 1;
            rd_addr = mem_addr;
        end
        if (mem_write === 1'b1) begin
            check_store();
            wr_pend = 1'b1;
            wr_addr = mem_addr;
            wr_data = mem_wdata;
        end
    end

    // memory model
    always @(posedge clk) begin
        cycle++;
        if (wr_pend) begin
            mem[wr_addr] = wr_data;
            wr_pend = 1'b0;
        end
        if (rd_wait > 0) begin
            rd_wait--;
            if (rd_wait == 0) begin
                mem_rdata <= #drive_delay mem[rd_addr];
            end
        end
    end

    // no backward branches, so every word runs at most once
    initial begin
        int limit;
        wait (prog_len != 0);
        limit = 12 * prog_len + 50;
        #(limit * clk_period);
        $display("core never halted within %0d cycles", limit);
        other_errors++;
        report_counts();
        $display("Result: FAILED");
        $finish;
    end

    initial begin
        reset_n   = 1'b0;
        mem_rdata = '0;
        load_stimulus();
        if (!file_ok) begin
            $display("stimulus file bench/stimulus.mem could not be read");
            other_errors++;
        end else begin
            repeat (reset_cycles) @(posedge clk);
            #drive_delay;
            reset_n = 1'b1;
            while (halted !== 1'b1) begin
                @(negedge clk);
            end
            repeat (quiet_cycles) begin
                @(negedge clk);
                if (mem_read !== 1'b0 || mem_write !== 1'b0) begin
                    $display("memory strobe at cycle %0d after the core halted", cycle);
                    other_errors++;
                end
                if (halted !== 1'b1) begin
                    $display("FAILED halted: expected %h, got %h", 1'b1, halted);
                    value_errors++;
                end
            end
            if (fetch_count != fetch_exp.size()) begin
                $display("saw %0d fetches but expected %0d", fetch_count, fetch_exp.size());
                other_errors++;
            end
            if (store_count != store_exp.size() / 2) begin
                $display("saw %0d stores but expected %0d", store_count, store_exp.size() / 2);
                other_errors++;
            end
        end
        report_counts();
        if (value_errors == 0 && other_errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

//--- bench/stimulus.mem
// three sections, each a hex count and then its words
// program words, store records as address data pairs, fetch addresses
0017
// addi r1=5, addi r2=-3, add r3, sub r4, and r5, or r6, addi r0 (discarded)
1205 143D 0650 0851 0A52 0C53 1047
// sw r3..r6 and r0 to e0..e4
3620 3821 3A22 3C23 3024
// lw r7 from e3, sw r7 through r6-8 (f5)
2E23 3FB8
// beq r1,r2 not taken, beq r0,r0 taken over two stray stores
4051 4002 3225 3226
// jal r7 to 15 over two stray stores, sw link to e6, halt
5E15 3227 3228 3E26 F000
0007
00E0 0002
00E1 0008
00E2 0005
00E3 FFFD
00E4 0000
00F5 FFFD
00E6 0013
0013
0000 0001 0002 0003 0004 0005 0006 0007
0008 0009 000A 000B 000C 000D 000E 000F
0012 0015 0016

//--- bench/tb_clock.sv
`timescale 1ns/1ps

module tb_clock #(
    parameter int period_ns = 100
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever begin
            #(period_ns / 2) clk = ~clk;
        end
    end

endmodule

//--- src/cpu_top.sv
`timescale 1ns/1ps

module cpu_top (
    input  logic                      clk,
    input  logic                      reset_n,
    input  logic [mc_pkg::word_w-1:0] mem_rdata,
    output logic [mc_pkg::addr_w-1:0] mem_addr,
    output logic [mc_pkg::word_w-1:0] mem_wdata,
    output logic                      mem_read,
    output logic                      mem_write,
    output logic                      halted
);
    import mc_pkg::*;

    logic                 ir_write;
    logic                 mdr_write;
    logic                 reg_write;
    logic                 pc_write;
    logic                 i_or_d;
    logic                 alu_src_imm;
    logic                 branch_taken;
    logic                 is_jal;
    logic                 is_branch;
    logic                 is_load;
    logic                 is_store;
    logic                 is_halt;
    logic [word_w-1:0]    instr;
    opcode_t              opcode;
    logic [reg_idx_w-1:0] rd;
    logic [reg_idx_w-1:0] rs;
    logic [reg_idx_w-1:0] rt;
    funct_t               funct;
    logic [word_w-1:0]    imm_ext;
    logic [jal_w-1:0]     jal_target;

    state_control u_ctrl (
        .clk          (clk),
        .reset_n      (reset_n),
        .is_jal       (is_jal),
        .is_branch    (is_branch),
        .is_load      (is_load),
        .is_store     (is_store),
        .is_halt      (is_halt),
        .branch_taken (branch_taken),
        .mem_read     (mem_read),
        .mem_write    (mem_write),
        .i_or_d       (i_or_d),
        .ir_write     (ir_write),
        .mdr_write    (mdr_write),
        .reg_write    (reg_write),
        .pc_write     (pc_write),
        .alu_src_imm  (alu_src_imm),
        .halted       (halted)
    );

    instr_decode u_dec (
        .instr      (instr),
        .opcode     (opcode),
        .rd         (rd),
        .rs         (rs),
        .rt         (rt),
        .funct      (funct),
        .imm_ext    (imm_ext),
        .jal_target (jal_target),
        .is_jal     (is_jal),
        .is_branch  (is_branch),
        .is_load    (is_load),
        .is_store   (is_store),
        .is_halt    (is_halt)
    );

    datapath u_dp (
        .clk          (clk),
        .reset_n      (reset_n),
        .mem_rdata    (mem_rdata),
        .ir_write     (ir_write),
        .mdr_write    (mdr_write),
        .reg_write    (reg_write),
        .pc_write     (pc_write),
        .i_or_d       (i_or_d),
        .alu_src_imm  (alu_src_imm),
        .opcode       (opcode),
        .rd           (rd),
        .rs           (rs),
        .rt           (rt),
        .funct        (funct),
        .imm_ext      (imm_ext),
        .jal_target   (jal_target),
        .instr        (instr),
        .mem_addr     (mem_addr),
        .mem_wdata    (mem_wdata),
        .branch_taken (branch_taken)
    );

endmodule

//--- src/datapath.sv
`timescale 1ns/1ps

module datapath (
    input  logic                         clk,
    input  logic                         reset_n,
    input  logic [mc_pkg::word_w-1:0]    mem_rdata,
    input  logic                         ir_write,
    input  logic                         mdr_write,
    input  logic                         reg_write,
    input  logic                         pc_write,
    input  logic                         i_or_d,
    input  logic                         alu_src_imm,
    input  mc_pkg::opcode_t              opcode,
    input  logic [mc_pkg::reg_idx_w-1:0] rd,
    input  logic [mc_pkg::reg_idx_w-1:0] rs,
    input  logic [mc_pkg::reg_idx_w-1:0] rt,
    input  mc_pkg::funct_t               funct,
    input  logic [mc_pkg::word_w-1:0]    imm_ext,
    input  logic [mc_pkg::jal_w-1:0]     jal_target,
    output logic [mc_pkg::word_w-1:0]    instr,
    output logic [mc_pkg::addr_w-1:0]    mem_addr,
    output logic [mc_pkg::word_w-1:0]    mem_wdata,
    output logic                         branch_taken
);
    import mc_pkg::*;

    logic [addr_w-1:0] pc;
    logic [addr_w-1:0] pc_plus1;
    logic [addr_w-1:0] next_pc;
    logic [word_w-1:0] ir;
    logic [word_w-1:0] mdr;
    logic [word_w-1:0] alu_out;
    logic [word_w-1:0] regs [reg_count];
    logic [word_w-1:0] rs_val;
    logic [word_w-1:0] rt_val;
    logic [word_w-1:0] alu_b;
    logic [word_w-1:0] alu_y;
    logic [word_w-1:0] wb_data;

    // while the IR loads, decode straight from the memory word
    assign instr = ir_write ? mem_rdata : ir;

    assign rs_val    = regs[rs];
    assign rt_val    = regs[rt];
    assign mem_wdata = regs[rd];
    assign mem_addr  = i_or_d ? alu_out[addr_w-1:0] : pc;
    assign pc_plus1  = pc + 1'b1;

    always_comb begin
        alu_b = (alu_src_imm || opcode == op_addi) ? imm_ext : rt_val;
        alu_y = rs_val + alu_b;
        if (opcode == op_alu) begin
            case (funct)
                fn_add:  alu_y = rs_val + alu_b;
                fn_sub:  alu_y = rs_val - alu_b;
                fn_and:  alu_y = rs_val & alu_b;
                default: alu_y = rs_val | alu_b;
            endcase
        end
    end

    always_comb begin
        case (opcode)
            op_lw:   wb_data = mdr;
            op_jal:  wb_data = {{(word_w - addr_w){1'b0}}, pc_plus1};
            default: wb_data = alu_out;
        endcase
    end

    // jal target bit 8 lies outside the 256-word space
    always_comb begin
        if (opcode == op_jal) begin
            next_pc = jal_target[addr_w-1:0];
        end else if (branch_taken) begin
            next_pc = pc_plus1 + imm_ext[addr_w-1:0];
        end else begin
            next_pc = pc_plus1;
        end
    end

    always_ff @(posedge clk) begin
        alu_out <= alu_y;
        if (ir_write) begin
            ir <= mem_rdata;
        end
        if (mdr_write) begin
            mdr <= mem_rdata;
        end
    end

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            pc           <= '0;
            branch_taken <= 1'b0;
        end else begin
            branch_taken <= (opcode == op_beq) && (rs_val == rt_val);
            if (pc_write) begin
                pc <= next_pc;
            end
        end
    end

    // r0 is never written, so it reads zero
    always_ff @(posedge clk) begin
        if (!reset_n) begin
            for (int i = 0; i < reg_count; i++) begin
                regs[i] <= '0;
            end
        end else if (reg_write && rd != '0) begin
            regs[rd] <= wb_data;
        end
    end

endmodule

//--- src/instr_decode.sv
`timescale 1ns/1ps

module instr_decode (
    input  logic [mc_pkg::word_w-1:0]    instr,
    output mc_pkg::opcode_t              opcode,
    output logic [mc_pkg::reg_idx_w-1:0] rd,
    output logic [mc_pkg::reg_idx_w-1:0] rs,
    output logic [mc_pkg::reg_idx_w-1:0] rt,
    output mc_pkg::funct_t               funct,
    output logic [mc_pkg::word_w-1:0]    imm_ext,
    output logic [mc_pkg::jal_w-1:0]     jal_target,
    output logic                         is_jal,
    output logic                         is_branch,
    output logic                         is_load,
    output logic                         is_store,
    output logic                         is_halt
);
    import mc_pkg::*;

    assign opcode     = opcode_t'(instr[15:12]);
    assign rd         = instr[11:9];
    assign rs         = instr[8:6];
    assign rt         = instr[5:3];
    assign funct      = funct_t'(instr[1:0]);
    assign jal_target = instr[jal_w-1:0];

    // sign-extended imm6
    assign imm_ext = {{(word_w - imm_w){instr[imm_w-1]}}, instr[imm_w-1:0]};

    always_comb begin
        is_jal    = 1'b0;
        is_branch = 1'b0;
        is_load   = 1'b0;
        is_store  = 1'b0;
        is_halt   = 1'b0;
        case (opcode)
            op_alu, op_addi: is_halt = 1'b0;
            op_lw:           is_load = 1'b1;
            op_sw:           is_store = 1'b1;
            op_beq:          is_branch = 1'b1;
            op_jal:          is_jal = 1'b1;
            // halt, plus anything undefined
            default:         is_halt = 1'b1;
        endcase
    end

endmodule

//--- src/mc_pkg.sv
package mc_pkg;

    localparam int word_w      = 16;
    localparam int addr_w      = 8;
    localparam int reg_count   = 8;
    localparam int reg_idx_w   = $clog2(reg_count);
    localparam int imm_w       = 6;
    localparam int jal_w       = 9;

    // read data valid this many edges after the edge that samples mem_read
    localparam int mem_latency = 2;

    typedef enum logic [3:0] {
        st_init,
        st_if1,
        st_if2,
        st_if3,
        st_if4,
        st_id,
        st_ex1,
        st_ex2,
        st_mem1,
        st_mem2,
        st_mem3,
        st_mem4,
        st_wb,
        st_halt
    } state_t;

    typedef enum logic [3:0] {
        op_alu  = 4'h0,
        op_addi = 4'h1,
        op_lw   = 4'h2,
        op_sw   = 4'h3,
        op_beq  = 4'h4,
        op_jal  = 4'h5,
        op_halt = 4'hf
    } opcode_t;

    typedef enum logic [1:0] {
        fn_add = 2'b00,
        fn_sub = 2'b01,
        fn_and = 2'b10,
        fn_or  = 2'b11
    } funct_t;

endpackage

//--- src/state_control.sv
`timescale 1ns/1ps

module state_control (
    input  logic clk,
    input  logic reset_n,
    input  logic is_jal,
    input  logic is_branch,
    input  logic is_load,
    input  logic is_store,
    input  logic is_halt,
    input  logic branch_taken,
    output logic mem_read,
    output logic mem_write,
    output logic i_or_d,
    output logic ir_write,
    output logic mdr_write,
    output logic reg_write,
    output logic pc_write,
    output logic alu_src_imm,
    output logic halted
);
    import mc_pkg::*;

    state_t state;
    state_t next_state;
    logic   mem_op;

    assign mem_op = is_load | is_store;

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            state <= st_init;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state  = state;
        mem_read    = 1'b0;
        mem_write   = 1'b0;
        i_or_d      = 1'b0;
        ir_write    = 1'b0;
        mdr_write   = 1'b0;
        reg_write   = 1'b0;
        pc_write    = 1'b0;
        alu_src_imm = 1'b0;
        halted      = 1'b0;

        case (state)
            st_init: next_state = st_if1;
            // instruction read at pc
            st_if1:  begin
                mem_read   = 1'b1;
                next_state = st_if2;
            end
            st_if2:  next_state = st_if3;
            st_if3:  next_state = st_if4;
            st_if4:  begin
                ir_write   = 1'b1;
                // decoder already sees the incoming word here
                next_state = is_jal ? st_ex1 : st_id;
            end
            st_id:   next_state = is_halt ? st_halt : st_ex1;
            st_ex1:  begin
                alu_src_imm = mem_op;
                next_state  = st_ex2;
            end
            st_ex2:  begin
                alu_src_imm = mem_op;
                if (is_branch) begin
                    // taken or not, beq retires here; branch_taken steers the pc
                    pc_write   = 1'b1;
                    next_state = st_if1;
                end else if (mem_op) begin
                    next_state = st_mem1;
                end else begin
                    next_state = st_wb;
                end
            end
            st_mem1: begin
                alu_src_imm = 1'b1;
                i_or_d      = 1'b1;
                mem_read    = is_load;
                mem_write   = is_store;
                next_state  = st_mem2;
            end
            st_mem2: begin
                alu_src_imm = 1'b1;
                next_state  = st_mem3;
            end
            st_mem3: begin
                alu_src_imm = 1'b1;
                next_state  = st_mem4;
            end
            st_mem4: begin
                alu_src_imm = 1'b1;
                if (is_load) begin
                    mdr_write  = 1'b1;
                    next_state = st_wb;
                end else begin
                    pc_write   = 1'b1;
                    next_state = st_if1;
                end
            end
            st_wb:   begin
                reg_write  = 1'b1;
                pc_write   = 1'b1;
                next_state = st_if1;
            end
            st_halt: halted = 1'b1;
            default: next_state = st_init;
        endcase
    end

endmodule

//--- vlog.f
src/mc_pkg.sv
src/state_control.sv
src/instr_decode.sv
src/datapath.sv
src/cpu_top.sv
bench/tb_clock.sv
bench/cpu_tb.sv
